// ==== hdl/alu_config.svh ====
/* alu configuration
   datapath, slice and opcode widths of the sliced alu */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////

// full datapath width
`define ALU_WIDTH 16

// the two low slices are six bits each
`define ALU_SLICE_W 6

// top slice also forms the flags
`define ALU_TOP_W 4

// operation code field
`define ALU_OP_W 3

// first bit of the middle and the top slice
`define ALU_MID_LSB (`ALU_SLICE_W)
`define ALU_TOP_LSB (2 * `ALU_SLICE_W)

`endif

// ==== hdl/alu_pkg.sv ====
/* alu package
   word, slice and opcode types and the structs shared by the alu blocks */
`include "alu_config.svh"

package alu_pkg;

   ////////////////////////////////////////////////////////////
   // vector types
   ////////////////////////////////////////////////////////////

   // one operand or result word
   typedef logic [`ALU_WIDTH-1:0] alu_word_t;

   // one low slice and the top slice
   typedef logic [`ALU_SLICE_W-1:0] alu_slice_t;
   typedef logic [`ALU_TOP_W-1:0]   alu_top_t;

   // operation codes, same order as the rom address field
   typedef enum logic [`ALU_OP_W-1:0] {
      ALU_ADD = 3'd0,
      ALU_ADC = 3'd1,
      ALU_SUB = 3'd2,
      ALU_AND = 3'd3,
      ALU_OR  = 3'd4,
      ALU_XOR = 3'd5,
      ALU_NOT = 3'd6,
      ALU_SHL = 3'd7
   } alu_op_t;

   ////////////////////////////////////////////////////////////
   // structs
   ////////////////////////////////////////////////////////////

   // registered operation, loaded on the alu_op strobe
   typedef struct packed {
      alu_op_t op;
      logic    x_in;
      logic    fl;
   } alu_cmd_t;

   // carry and shift bit passed from one slice to the next
   typedef struct packed {
      logic c;
      logic x;
   } alu_cascade_t;

   // flag values and raw set requests from the top slice
   typedef struct packed {
      logic l_val;
      logic set_l;
      logic v_val;
      logic set_v;
   } alu_flags_t;

endpackage

// ==== hdl/alu_ctrl.sv ====
/* alu control
   operation register, bus enable and gating of the flag set strobes */
module alu_ctrl
   import alu_pkg::*;
(
   input  logic       t34,
   input  logic       arst_n,
   input  logic       alu_op,
   input  logic       read_alu_y,
   input  logic       fl,
   input  logic       x_in,
   input  alu_op_t    op_code,
   input  alu_flags_t flags_raw,
   output alu_cmd_t   cmd,
   output logic       ibus_oe,
   output logic       fl_out,
   output logic       set_l,
   output logic       fv_out,
   output logic       set_v
);

   // high for the cycle after an alu_op edge
   logic op_active;

   ////////////////////////////////////////////////////////////
   // operation register
   ////////////////////////////////////////////////////////////

   // op code, serial x and link are captured together
   // so the slices see one stable command for the whole result
   always_ff @(posedge t34 or negedge arst_n) begin
      if (!arst_n) begin
         cmd <= alu_cmd_t'{op: ALU_ADD, x_in: 1'b0, fl: 1'b0};
      end else if (alu_op) begin
         // a new strobe simply replaces the old command
         cmd <= alu_cmd_t'{op: op_code, x_in: x_in, fl: fl};
      end
   end

   // follows alu_op by one cycle
   // back to back strobes keep it high
   always_ff @(posedge t34 or negedge arst_n) begin
      if (!arst_n) begin
         op_active <= 1'b0;
      end else begin
         op_active <= alu_op;
      end
   end

   ////////////////////////////////////////////////////////////
   // bus enable
   ////////////////////////////////////////////////////////////

   // result drives the bus while it is being read
   // and in the cycle right after the operation is latched
   always_comb begin
      ibus_oe = read_alu_y | op_active;
   end

   ////////////////////////////////////////////////////////////
   // flags
   ////////////////////////////////////////////////////////////

   // flag values pass straight through from the top slice
   always_comb begin
      fl_out = flags_raw.l_val;
      fv_out = flags_raw.v_val;
   end

   // set requests only count when the result is stored
   always_comb begin
      set_l = flags_raw.set_l & read_alu_y;
      set_v = flags_raw.set_v & read_alu_y;
   end

endmodule

// ==== hdl/alu_slice.sv ====
/* alu slice
   one W-bit slice of every alu operation, with carry and shift cascade */
`include "alu_config.svh"

module alu_slice
   import alu_pkg::*;
#(
   parameter int W = `ALU_SLICE_W
) (
   input  alu_cmd_t     cmd,
   input  logic [W-1:0] a_part,
   input  logic [W-1:0] b_part,
   input  alu_cascade_t cascade_in,
   input  logic         first,
   output logic [W-1:0] y_part,
   output alu_cascade_t cascade_out
);

   logic         is_arith;
   logic         c_in;
   logic [W-1:0] b_eff;
   logic [W:0]   sum;

   // add, adc and sub share the adder
   assign is_arith = (cmd.op == ALU_ADD) || (cmd.op == ALU_ADC) || (cmd.op == ALU_SUB);

   ////////////////////////////////////////////////////////////
   // carry in
   ////////////////////////////////////////////////////////////

   // lowest slice forms the carry from the command
   // upper slices take it from the slice below
   always_comb begin
      if (first) begin
         case (cmd.op)
            ALU_ADC: c_in = cmd.fl;
            ALU_SUB: c_in = 1'b1;
            default: c_in = 1'b0;
         endcase
      end else begin
         c_in = cascade_in.c;
      end
   end

   // sub is a plus inverted b plus one
   assign b_eff = (cmd.op == ALU_SUB) ? ~b_part : b_part;
   assign sum   = {1'b0, a_part} + {1'b0, b_eff} + {{W{1'b0}}, c_in};

   ////////////////////////////////////////////////////////////
   // result
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (cmd.op)
         ALU_AND: y_part = a_part & b_part;
         ALU_OR:  y_part = a_part | b_part;
         ALU_XOR: y_part = a_part ^ b_part;
         ALU_NOT: y_part = ~a_part;
         // shift bit from below enters bit 0
         ALU_SHL: y_part = {a_part[W-2:0], cascade_in.x};
         default: y_part = sum[W-1:0];
      endcase
   end

   // carry only ripples for the arithmetic ops
   assign cascade_out.c = is_arith & sum[W];
   // top bit moves up for shl
   assign cascade_out.x = a_part[W-1];

endmodule

// ==== hdl/alu_flag_slice.sv ====
/* alu flag slice
   top four result bits plus link and overflow values and set requests */
`include "alu_config.svh"

module alu_flag_slice
   import alu_pkg::*;
(
   input  alu_cmd_t     cmd,
   input  alu_top_t     a_part,
   input  alu_top_t     b_part,
   input  alu_cascade_t cascade_in,
   output alu_top_t     y_part,
   output alu_flags_t   flags_raw
);

   localparam int TW = `ALU_TOP_W;

   logic         is_arith;
   logic         is_shl;
   logic         carry_out;
   logic         ovf;
   alu_top_t     b_eff;
   logic [TW:0]  sum;

   // operation classes that touch the flags
   assign is_arith = (cmd.op == ALU_ADD) || (cmd.op == ALU_ADC) || (cmd.op == ALU_SUB);
   assign is_shl   = (cmd.op == ALU_SHL);

   ////////////////////////////////////////////////////////////
   // adder
   ////////////////////////////////////////////////////////////

   // inverted b for sub
   // the plus one already came in as the low slice carry
   assign b_eff = (cmd.op == ALU_SUB) ? ~b_part : b_part;
   assign sum   = {1'b0, a_part} + {1'b0, b_eff} + {{TW{1'b0}}, cascade_in.c};

   // carry out of bit 15
   assign carry_out = sum[TW];

   // signed overflow
   // both addends share a sign that the sum does not
   assign ovf = (a_part[TW-1] == b_eff[TW-1]) && (sum[TW-1] != a_part[TW-1]);

   ////////////////////////////////////////////////////////////
   // result
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (cmd.op)
         ALU_AND: y_part = a_part & b_part;
         ALU_OR:  y_part = a_part | b_part;
         ALU_XOR: y_part = a_part ^ b_part;
         ALU_NOT: y_part = ~a_part;
         ALU_SHL: y_part = {a_part[TW-2:0], cascade_in.x};
         default: y_part = sum[TW-1:0];
      endcase
   end

   ////////////////////////////////////////////////////////////
   // flags
   ////////////////////////////////////////////////////////////

   // link gets the carry for arithmetic
   // and the bit shifted out of the word for shl
   always_comb begin
      if (is_arith) begin
         flags_raw.l_val = carry_out;
      end else if (is_shl) begin
         flags_raw.l_val = a_part[TW-1];
      end else begin
         flags_raw.l_val = 1'b0;
      end
   end

   // raw requests, gated with read_alu_y in the control block
   always_comb begin
      flags_raw.set_l = is_arith | is_shl;
      flags_raw.v_val = is_arith & ovf;
      flags_raw.set_v = is_arith;
   end

endmodule

// ==== hdl/alu_rom_unit.sv ====
/* alu unit
   control block and three cascaded slices forming the 16-bit alu */
`include "alu_config.svh"

module alu_rom_unit
   import alu_pkg::*;
(
   input  logic      t34,
   input  logic      arst_n,
   input  logic      alu_op,
   input  logic      read_alu_y,
   input  logic      fl,
   input  logic      x_in,
   input  alu_op_t   op_code,
   input  alu_word_t a,
   input  alu_word_t b,
   output alu_word_t ibus,
   output logic      ibus_oe,
   output logic      fl_out,
   output logic      set_l,
   output logic      fv_out,
   output logic      set_v
);

   alu_cmd_t     cmd;
   alu_flags_t   flags_raw;
   alu_cascade_t casc_lo_in;
   alu_cascade_t casc_lo;
   alu_cascade_t casc_mid;
   alu_slice_t   y_lo;
   alu_slice_t   y_mid;
   alu_top_t     y_top;

   ////////////////////////////////////////////////////////////
   // control
   ////////////////////////////////////////////////////////////

   alu_ctrl ctrl_i (
      .t34        (t34),
      .arst_n     (arst_n),
      .alu_op     (alu_op),
      .read_alu_y (read_alu_y),
      .fl         (fl),
      .x_in       (x_in),
      .op_code    (op_code),
      .flags_raw  (flags_raw),
      .cmd        (cmd),
      .ibus_oe    (ibus_oe),
      .fl_out     (fl_out),
      .set_l      (set_l),
      .fv_out     (fv_out),
      .set_v      (set_v)
   );

   ////////////////////////////////////////////////////////////
   // slices
   ////////////////////////////////////////////////////////////

   // serial x enters the low slice
   // its carry comes from cmd inside the slice so c is tied low
   assign casc_lo_in = alu_cascade_t'{c: 1'b0, x: cmd.x_in};

   alu_slice #(.W(`ALU_SLICE_W)) slice_lo_i (
      .cmd         (cmd),
      .a_part      (a[`ALU_MID_LSB-1:0]),
      .b_part      (b[`ALU_MID_LSB-1:0]),
      .cascade_in  (casc_lo_in),
      .first       (1'b1),
      .y_part      (y_lo),
      .cascade_out (casc_lo)
   );

   alu_slice #(.W(`ALU_SLICE_W)) slice_mid_i (
      .cmd         (cmd),
      .a_part      (a[`ALU_TOP_LSB-1:`ALU_MID_LSB]),
      .b_part      (b[`ALU_TOP_LSB-1:`ALU_MID_LSB]),
      .cascade_in  (casc_lo),
      .first       (1'b0),
      .y_part      (y_mid),
      .cascade_out (casc_mid)
   );

   alu_flag_slice slice_top_i (
      .cmd        (cmd),
      .a_part     (a[`ALU_WIDTH-1:`ALU_TOP_LSB]),
      .b_part     (b[`ALU_WIDTH-1:`ALU_TOP_LSB]),
      .cascade_in (casc_mid),
      .y_part     (y_top),
      .flags_raw  (flags_raw)
   );

   // bus value, qualified by ibus_oe
   assign ibus = {y_top, y_mid, y_lo};

endmodule

// ==== tests/tb_clk_gen.sv ====
/* testbench clock and reset
   10 ns clock on t34, arst_n held low for the first two cycles */
module tb_clk_gen (
   output logic t34,
   output logic arst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      t34 = 1'b0;
      forever #5 t34 = ~t34;
   end

   // release reset just after the second rising edge
   initial begin
      arst_n = 1'b0;
      repeat (2) @(posedge t34);
      #1 arst_n = 1'b1;
   end

endmodule

// ==== tests/alu_rom_unit_assert.sv ====
/* alu control assertions
   bus enable, op_active pulse and flag strobe gating, bound into alu_ctrl */
module alu_rom_unit_assert (
   input logic t34,
   input logic arst_n,
   input logic alu_op,
   input logic read_alu_y,
   input logic op_active,
   input logic ibus_oe,
   input logic set_l,
   input logic set_v
);
   timeunit 1ns;
   timeprecision 100ps;

   // number of failed assertions, read by the testbench
   int fail_count = 0;

   ////////////////////////////////////////////////////////////
   // flag strobes
   ////////////////////////////////////////////////////////////

   // flags only change when the result is stored
   set_l_needs_read: assert property (@(posedge t34) disable iff (!arst_n)
      set_l |-> read_alu_y)
      else begin
         fail_count++;
         $error("set_l high while read_alu_y is low");
      end

   set_v_needs_read: assert property (@(posedge t34) disable iff (!arst_n)
      set_v |-> read_alu_y)
      else begin
         fail_count++;
         $error("set_v high while read_alu_y is low");
      end

   ////////////////////////////////////////////////////////////
   // op_active and bus enable
   ////////////////////////////////////////////////////////////

   // single pulse unless a second strobe follows
   op_active_pulse: assert property (@(posedge t34) disable iff (!arst_n)
      ($rose(op_active) && !alu_op) |=> !op_active)
      else begin
         fail_count++;
         $error("op_active stayed high without a new alu_op");
      end

   // bus driven while read or in the one cycle after a strobe
   bus_enable_rule: assert property (@(posedge t34) disable iff (!arst_n)
      ibus_oe == (read_alu_y || $past(alu_op)))
      else begin
         fail_count++;
         $error("ibus_oe differs from read_alu_y or the cycle after alu_op");
      end

endmodule

bind alu_ctrl alu_rom_unit_assert assert_i (
   .t34        (t34),
   .arst_n     (arst_n),
   .alu_op     (alu_op),
   .read_alu_y (read_alu_y),
   .op_active  (op_active),
   .ibus_oe    (ibus_oe),
   .set_l      (set_l),
   .set_v      (set_v)
);

// ==== tests/tb_alu_rom_unit.sv ====
/* alu unit testbench
   directed tests against a behavioral model of the eight alu operations */
module tb_alu_rom_unit
   import alu_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WAIT_LIMIT = 8;

   logic       t34;
   logic       arst_n;
   logic       alu_op;
   logic       read_alu_y;
   logic       fl;
   logic       x_in;
   alu_op_t    op_code;
   alu_word_t  a;
   alu_word_t  b;
   alu_word_t  ibus;
   logic       ibus_oe;
   logic       fl_out;
   logic       set_l;
   logic       fv_out;
   logic       set_v;
   int         errors;
   int         test_errors;
   int         checks;
   int         tests;

   tb_clk_gen clk_i (.t34(t34), .arst_n(arst_n));

   alu_rom_unit dut_i (.*);

   ////////////////////////////////////////////////////////////
   // model and compare tasks
   ////////////////////////////////////////////////////////////

   // expected word and flags, from signed and unsigned integer math
   function automatic void model_op(input alu_op_t op, input alu_word_t ma,
         input alu_word_t mb, input logic mfl, input logic mx,
         output alu_word_t y, output alu_flags_t f);
      int u;
      int s;
      f = '0;
      y = '0;
      case (op)
         ALU_ADD, ALU_ADC: begin
            u = int'(ma) + int'(mb) + ((op == ALU_ADC) ? int'(mfl) : 0);
            s = int'($signed(ma)) + int'($signed(mb)) + ((op == ALU_ADC) ? int'(mfl) : 0);
            y = alu_word_t'(u);
            f = alu_flags_t'{l_val: u > 65535, set_l: 1'b1,
                             v_val: (s > 32767) || (s < -32768), set_v: 1'b1};
         end
         ALU_SUB: begin
            s = int'($signed(ma)) - int'($signed(mb));
            y = ma - mb;
            // no borrow means carry out is set
            f = alu_flags_t'{l_val: ma >= mb, set_l: 1'b1,
                             v_val: (s > 32767) || (s < -32768), set_v: 1'b1};
         end
         ALU_AND: y = ma & mb;
         ALU_OR:  y = ma | mb;
         ALU_XOR: y = ma ^ mb;
         ALU_NOT: y = ~ma;
         default: begin
            y = {ma[14:0], mx};
            f.l_val = ma[15];
            f.set_l = 1'b1;
         end
      endcase
   endfunction

   function automatic alu_flags_t dut_flags();
      return alu_flags_t'{l_val: fl_out, set_l: set_l, v_val: fv_out, set_v: set_v};
   endfunction

   task automatic check_word(input string name, input alu_word_t exp, input alu_word_t act);
      checks++;
      if (exp !== act) begin
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_flags(input string name, input alu_flags_t exp, input alu_flags_t act);
      checks++;
      if (exp !== act) begin
         $display("CHECK FAILED %s flags expected %b actual %b", name, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (exp !== act) begin
         $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
         test_errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %-10s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "bad",
               test_errors);
      errors += test_errors;
      test_errors = 0;
   endtask

   ////////////////////////////////////////////////////////////
   // drive helpers
   ////////////////////////////////////////////////////////////

   // reset release, bounded by the wait limit
   task automatic wait_reset_release();
      int n;
      n = 0;
      while (!arst_n && n < WAIT_LIMIT) begin
         @(posedge t34);
         n++;
      end
      if (!arst_n) begin
         $display("timeout: arst_n was never released");
         test_errors++;
      end
   endtask

   // drops alu_op after one edge, then waits for op_active on the bus enable
   task automatic wait_bus_enable(input string name);
      logic seen;
      int   n;
      seen = 1'b0;
      n = 0;
      while (!seen && n < WAIT_LIMIT) begin
         @(posedge t34);
         #1;
         alu_op = 1'b0;
         seen = ibus_oe;
         n++;
      end
      if (!seen) begin
         $display("timeout in %s: ibus_oe never rose after alu_op", name);
         test_errors++;
      end else if (n != 1) begin
         $display("%s: ibus_oe rose %0d cycles after alu_op instead of 1", name, n);
         test_errors++;
      end
   endtask

   task automatic start_op(input alu_op_t op, input alu_word_t op_a, input alu_word_t op_b,
         input logic op_fl, input logic op_x);
      @(posedge t34);
      #1;
      alu_op = 1'b1;
      op_code = op;
      a = op_a;
      b = op_b;
      fl = op_fl;
      x_in = op_x;
      read_alu_y = 1'b0;
   endtask

   // one full operation, result read with read_alu_y high
   task automatic run_op(input string name, input alu_op_t op, input alu_word_t op_a,
         input alu_word_t op_b, input logic op_fl, input logic op_x);
      alu_word_t  exp_y;
      alu_flags_t exp_f;
      model_op(op, op_a, op_b, op_fl, op_x, exp_y, exp_f);
      start_op(op, op_a, op_b, op_fl, op_x);
      wait_bus_enable(name);
      read_alu_y = 1'b1;
      #3;
      check_word(name, exp_y, ibus);
      check_flags(name, exp_f, dut_flags());
      @(posedge t34);
      #1;
      read_alu_y = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////

   task automatic test_reset();
      check_bit("reset oe", 1'b0, ibus_oe);
      check_bit("reset set_l", 1'b0, set_l);
      check_bit("reset set_v", 1'b0, set_v);
      end_test("reset");
   endtask

   // carries across both slice boundaries
   task automatic test_arith();
      run_op("add", ALU_ADD, 16'hffff, 16'h0001, 1'b0, 1'b0);
      run_op("add", ALU_ADD, 16'h7fff, 16'h0001, 1'b0, 1'b0);
      run_op("add", ALU_ADD, 16'h003f, 16'h0001, 1'b0, 1'b0);
      run_op("adc", ALU_ADC, 16'h0fff, 16'h0000, 1'b1, 1'b0);
      run_op("adc", ALU_ADC, 16'hffff, 16'h0000, 1'b0, 1'b0);
      run_op("sub", ALU_SUB, 16'h0000, 16'h0001, 1'b0, 1'b0);
      run_op("sub", ALU_SUB, 16'h8000, 16'h0001, 1'b0, 1'b0);
      repeat (6) begin
         run_op("add rnd", ALU_ADD, alu_word_t'($urandom), alu_word_t'($urandom), 1'b0, 1'b0);
         run_op("adc rnd", ALU_ADC, alu_word_t'($urandom), alu_word_t'($urandom),
                1'($urandom), 1'b0);
         run_op("sub rnd", ALU_SUB, alu_word_t'($urandom), alu_word_t'($urandom), 1'b0, 1'b0);
      end
      end_test("arith");
   endtask

   // model gives zero set requests for these
   task automatic test_logic();
      repeat (4) begin
         run_op("and", ALU_AND, alu_word_t'($urandom), alu_word_t'($urandom), 1'b1, 1'b0);
         run_op("or", ALU_OR, alu_word_t'($urandom), alu_word_t'($urandom), 1'b0, 1'b1);
         run_op("xor", ALU_XOR, alu_word_t'($urandom), alu_word_t'($urandom), 1'b1, 1'b0);
         run_op("not", ALU_NOT, alu_word_t'($urandom), alu_word_t'($urandom), 1'b0, 1'b0);
      end
      end_test("logic");
   endtask

   // bits 5 and 11 cross the slice boundaries
   task automatic test_shl();
      run_op("shl", ALU_SHL, 16'h8820, 16'h0000, 1'b0, 1'b0);
      run_op("shl", ALU_SHL, 16'h0820, 16'h0000, 1'b0, 1'b1);
      run_op("shl", ALU_SHL, alu_word_t'($urandom), 16'h0000, 1'b0, 1'b1);
      end_test("shl");
   endtask

   task automatic test_bus_enable();
      start_op(ALU_SUB, 16'h1234, 16'h4321, 1'b0, 1'b0);
      wait_bus_enable("bus_enable");
      #2;
      check_bit("oe pulse", 1'b1, ibus_oe);
      check_bit("oe set_l", 1'b0, set_l);
      check_bit("oe set_v", 1'b0, set_v);
      @(posedge t34);
      #3;
      check_bit("oe release", 1'b0, ibus_oe);
      end_test("bus_enable");
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      alu_op = 1'b0;
      read_alu_y = 1'b0;
      fl = 1'b0;
      x_in = 1'b0;
      op_code = ALU_ADD;
      a = '0;
      b = '0;
      errors = 0;
      test_errors = 0;
      checks = 0;
      tests = 0;
      void'($urandom(32'hcf33));
      wait_reset_release();
      @(posedge t34);
      #1;
      test_reset();
      test_arith();
      test_logic();
      test_shl();
      test_bus_enable();
      // failures of the bound assertions
      errors += dut_i.ctrl_i.assert_i.fail_count;
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // overall limit on the run
   initial begin
      #200us;
      $display("timeout: run did not finish");
      $display("sim failed");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/alu_pkg.sv
hdl/alu_ctrl.sv
hdl/alu_slice.sv
hdl/alu_flag_slice.sv
hdl/alu_rom_unit.sv
tests/tb_clk_gen.sv
tests/alu_rom_unit_assert.sv
tests/tb_alu_rom_unit.sv

// ==== Bender.yml ====
package:
  name: alu_rom_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/alu_pkg.sv
      - hdl/alu_ctrl.sv
      - hdl/alu_slice.sv
      - hdl/alu_flag_slice.sv
      - hdl/alu_rom_unit.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/alu_rom_unit_assert.sv
      - tests/tb_alu_rom_unit.sv
